/* design/glb_bank.sv */
// single-port bank memory of the global buffer
//   256 words of one bank word each
//   write in the strobe cycle, registered read one cycle later

`timescale 1ns/1ns

module glb_bank import glb_pkg::*; (
    input  logic       clk,
    input  logic       wr_en,                          // store req.data at req.addr
    input  logic       rd_en,                          // fetch word at req.addr
    input  bank_req_t  req,                            // address and write word
    output bank_data_t rd_data                         // read word, holds between reads
);

    localparam int BANK_WORDS = 2 ** BANK_ADDR_WIDTH;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // behaves like an sram macro, contents undefined after power up
    bank_data_t mem [0:BANK_WORDS-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[req.addr] <= req.data;                 // write lands at the edge
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the output register only loads on a read, so the last word stays
    // visible until the next read replaces it
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[req.addr];                  // word valid next cycle
        end
    end

    // the same address is never read and written in one cycle, so the
    // read-during-write behaviour is left to the memory model

endmodule

/* design/glb_config.sv */
// configuration block of the global buffer
//   bank enable mask, resets to all banks on
//   saturating counter of dropped accesses
//   registered register read port

`timescale 1ns/1ns

module glb_config import glb_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  cfg_req_t                  cfg,             // host register access
    output logic [CFG_DATA_WIDTH-1:0] cfg_rd_data,     // valid the cycle after a read
    output logic [NUM_BANKS-1:0]      bank_enable,     // to the interconnect
    input  logic                      drop             // dropped access pulse
);

    logic [CFG_DATA_WIDTH-1:0] drop_count;
    logic [CFG_DATA_WIDTH-1:0] mask_ext;               // mask zero-extended for readback
    logic                      wr_mask;
    logic                      wr_count;

    assign wr_mask  = cfg.wr_en && (cfg.addr == CFG_BANK_ENABLE);
    assign wr_count = cfg.wr_en && (cfg.addr == CFG_DROP_COUNT);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_enable <= '1;                         // all banks on
        end else if (wr_mask) begin
            bank_enable <= cfg.data[NUM_BANKS-1:0];    // upper bits ignored
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            drop_count <= '0;
        end else if (wr_count) begin
            drop_count <= '0;                          // any write clears
        end else if (drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;           // stops at the top
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mask_ext                = '0;
        mask_ext[NUM_BANKS-1:0] = bank_enable;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rd_data <= '0;
        end else if (cfg.rd_en) begin
            case (cfg.addr)
                CFG_BANK_ENABLE: cfg_rd_data <= mask_ext;
                CFG_DROP_COUNT:  cfg_rd_data <= drop_count;
                default:         cfg_rd_data <= '0;    // unmapped
            endcase
        end
    end

endmodule

/* design/glb_pkg.sv */
// shared definitions for the global buffer
//   bank word and bank address widths
//   config register widths and register map
//   bank request and config request structs

package glb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bank geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int BANK_DATA_WIDTH = 64;               // one bank word
    localparam int BANK_ADDR_WIDTH = 8;                // 256 words per bank

    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;

    // request seen by every bank, the address is the in-bank word index
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] addr;              // word inside the bank
        bank_data_t                 data;              // write word
    } bank_req_t;                                      // 72 bits

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // config register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CFG_ADDR_WIDTH = 2;
    localparam int CFG_DATA_WIDTH = 32;

    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_BANK_ENABLE = 2'd0;  // per-bank enable mask
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_DROP_COUNT  = 2'd1;  // dropped access count

    // host side config access, plain strobes
    typedef struct packed {
        logic                      wr_en;              // write strobe
        logic                      rd_en;              // read strobe
        logic [CFG_ADDR_WIDTH-1:0] addr;               // register select
        logic [CFG_DATA_WIDTH-1:0] data;               // write data
    } cfg_req_t;                                       // 36 bits

    // addresses 2 and 3 are unmapped and read as zero

endpackage

/* design/global_buffer.sv */
// global buffer top level
//   host to bank interconnect
//   configuration block
//   row of NUM_BANKS bank memories

`timescale 1ns/1ns

module global_buffer import glb_pkg::*; #(
    parameter  int NUM_BANKS      = 4,
    localparam int GLB_ADDR_WIDTH = BANK_ADDR_WIDTH + $clog2(NUM_BANKS)
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      host_wr_en,
    input  logic [GLB_ADDR_WIDTH-1:0] host_wr_addr,
    input  bank_data_t                host_wr_data,

    input  logic                      host_rd_en,
    input  logic [GLB_ADDR_WIDTH-1:0] host_rd_addr,
    output bank_data_t                host_rd_data,

    input  cfg_req_t                  cfg,
    output logic [CFG_DATA_WIDTH-1:0] cfg_rd_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [NUM_BANKS-1:0] bank_enable;                 // config to interconnect
    logic                 drop;                        // interconnect to config
    logic                 bank_wr_en   [NUM_BANKS-1:0];
    logic                 bank_rd_en   [NUM_BANKS-1:0];
    bank_req_t            bank_req     [NUM_BANKS-1:0];
    bank_data_t           bank_rd_data [NUM_BANKS-1:0];

    host_bank_interconnect #(.NUM_BANKS(NUM_BANKS)) i_host_bank_interconnect (
        .clk          (clk),
        .reset        (reset),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (host_rd_data),
        .bank_enable  (bank_enable),
        .drop         (drop),
        .bank_wr_en   (bank_wr_en),
        .bank_rd_en   (bank_rd_en),
        .bank_req     (bank_req),
        .bank_rd_data (bank_rd_data)
    );

    glb_config #(.NUM_BANKS(NUM_BANKS)) i_glb_config (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .cfg_rd_data (cfg_rd_data),
        .bank_enable (bank_enable),
        .drop        (drop)
    );

    // one memory per bank, bank i holds global addresses with bank field i
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        glb_bank i_glb_bank (
            .clk     (clk),
            .wr_en   (bank_wr_en[g]),
            .rd_en   (bank_rd_en[g]),
            .req     (bank_req[g]),
            .rd_data (bank_rd_data[g])
        );
    end

endmodule

/* design/host_bank_interconnect.sv */
// host to bank interconnect
//   bank decode from the high address bits, gated by the enable mask
//   write and address fan-out to every bank
//   drop pulse for accesses to disabled banks
//   two-stage read return pipeline with a held output word

`timescale 1ns/1ns

module host_bank_interconnect import glb_pkg::*; #(
    parameter  int NUM_BANKS      = 4,
    localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS),
    localparam int GLB_ADDR_WIDTH = BANK_ADDR_WIDTH + BANK_SEL_WIDTH
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      host_wr_en,
    input  logic [GLB_ADDR_WIDTH-1:0] host_wr_addr,
    input  bank_data_t                host_wr_data,

    input  logic                      host_rd_en,
    input  logic [GLB_ADDR_WIDTH-1:0] host_rd_addr,
    output bank_data_t                host_rd_data,

    input  logic [NUM_BANKS-1:0]      bank_enable,     // from the config block
    output logic                      drop,            // one pulse per dropped access

    output logic                      bank_wr_en   [NUM_BANKS-1:0],
    output logic                      bank_rd_en   [NUM_BANKS-1:0],
    output bank_req_t                 bank_req     [NUM_BANKS-1:0],
    input  bank_data_t                bank_rd_data [NUM_BANKS-1:0]
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address split and bank decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [BANK_SEL_WIDTH-1:0]  wr_sel;                // bank field of write address
    logic [BANK_SEL_WIDTH-1:0]  rd_sel;                // bank field of read address
    logic [BANK_ADDR_WIDTH-1:0] wr_word;               // in-bank write address
    logic [BANK_ADDR_WIDTH-1:0] rd_word;               // in-bank read address
    logic [NUM_BANKS-1:0]       wr_dec;                // one-hot, before enable gating
    logic [NUM_BANKS-1:0]       rd_dec;
    logic                       wr_hit;                // write targets an enabled bank
    logic                       rd_hit;                // read targets an enabled bank

    assign wr_sel  = host_wr_addr[BANK_ADDR_WIDTH +: BANK_SEL_WIDTH];
    assign rd_sel  = host_rd_addr[BANK_ADDR_WIDTH +: BANK_SEL_WIDTH];
    assign wr_word = host_wr_addr[0 +: BANK_ADDR_WIDTH];
    assign rd_word = host_rd_addr[0 +: BANK_ADDR_WIDTH];

    assign wr_hit = bank_enable[wr_sel];
    assign rd_hit = bank_enable[rd_sel];

    // a strobe aimed at a disabled bank never reaches the memory
    assign drop = (host_wr_en && !wr_hit) || (host_rd_en && !rd_hit);

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            wr_dec[i]     = host_wr_en && (wr_sel == BANK_SEL_WIDTH'(i));
            rd_dec[i]     = host_rd_en && (rd_sel == BANK_SEL_WIDTH'(i));
            bank_wr_en[i] = wr_dec[i] && bank_enable[i];   // gated by mask
            bank_rd_en[i] = rd_dec[i] && bank_enable[i];
            // the write owns the address of the bank it selects
            bank_req[i].addr = wr_dec[i] ? wr_word : rd_word;
            bank_req[i].data = host_wr_data;               // same word to all banks
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read return pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic                      rd_vld_d1;              // read issued one cycle ago
    logic                      rd_vld_d2;              // read result due this cycle
    logic                      rd_hit_d1;
    logic                      rd_hit_d2;
    logic [BANK_SEL_WIDTH-1:0] rd_sel_d1;
    logic [BANK_SEL_WIDTH-1:0] rd_sel_d2;
    bank_data_t                rd_word_d1 [NUM_BANKS-1:0];  // registered bank returns
    bank_data_t                rd_new;                 // result of the completing read
    bank_data_t                rd_held;                // last completed result

    // select and hit flag travel beside the data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_vld_d1 <= 1'b0;
            rd_vld_d2 <= 1'b0;
            rd_hit_d1 <= 1'b0;
            rd_hit_d2 <= 1'b0;
            rd_sel_d1 <= '0;
            rd_sel_d2 <= '0;
        end else begin
            rd_vld_d1 <= host_rd_en;
            rd_vld_d2 <= rd_vld_d1;
            rd_hit_d1 <= rd_hit;
            rd_hit_d2 <= rd_hit_d1;
            rd_sel_d1 <= rd_sel;
            rd_sel_d2 <= rd_sel_d1;
        end
    end

    // bank words arrive in n+1 and are captured at the end of n+1
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            rd_word_d1[i] <= bank_rd_data[i];
        end
    end

    assign rd_new = rd_hit_d2 ? rd_word_d1[rd_sel_d2] : '0;   // missed read gives zero

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_held <= '0;
        end else if (rd_vld_d2) begin
            rd_held <= rd_new;                         // keep it for idle cycles
        end
    end

    // new result shows in n+2 itself, the held copy covers the cycles after
    assign host_rd_data = rd_vld_d2 ? rd_new : rd_held;

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the global buffer testbench with verilator
# the run passes only when the simulation output holds the pass message

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal \
    --top-module tb_global_buffer \
    --Mdir obj_dir \
    -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_global_buffer 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation passed"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

/* src.f */
+incdir+tests
design/glb_pkg.sv
design/glb_bank.sv
design/host_bank_interconnect.sv
design/glb_config.sv
design/global_buffer.sv
tests/tb_global_buffer.sv

/* tests/glb_model.svh */
// reference model of the global buffer for the testbench
//   word store over the whole global address space
//   enable mask and dropped access count
//   queue of expected read results tagged with the issue cycle

`ifndef GLB_MODEL_SVH
`define GLB_MODEL_SVH

bank_data_t           model_mem [0:GLB_WORDS-1];      // expected memory contents
logic [NUM_BANKS-1:0] model_mask;                     // expected enable mask
int unsigned          model_drops;                    // expected drop counter
bank_data_t           exp_data  [$];                  // read results in flight
int                   exp_cycle [$];                  // issue cycle of each result

// high bits of the global address pick the bank
function automatic int bank_of(input logic [GLB_ADDR_WIDTH-1:0] addr);
    return int'(addr >> BANK_ADDR_WIDTH);
endfunction

// a write to a disabled bank is lost and counted
function automatic void store_expected(input logic [GLB_ADDR_WIDTH-1:0] addr,
                                       input bank_data_t data);
    if (model_mask[bank_of(addr)]) begin
        model_mem[addr] = data;
    end else begin
        model_drops++;
    end
endfunction

// a read of a disabled bank returns zero and is counted
function automatic bank_data_t expected_read(input logic [GLB_ADDR_WIDTH-1:0] addr);
    if (model_mask[bank_of(addr)]) begin
        return model_mem[addr];
    end
    model_drops++;
    return '0;
endfunction

`endif

/* tests/tb_global_buffer.sv */
// testbench of the global buffer
//   clock, reset and xorshift stimulus
//   checks against the model in glb_model.svh
//   watchdog and DUT instance

`timescale 1ns/1ns

module tb_global_buffer import glb_pkg::*; ();

    localparam int NUM_BANKS      = 4;
    localparam int GLB_ADDR_WIDTH = BANK_ADDR_WIDTH + $clog2(NUM_BANKS);
    localparam int GLB_WORDS      = 2 ** GLB_ADDR_WIDTH;
    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;                // inputs change after the edge
    localparam int RESET_CYCLES   = 2;
    localparam int RAND_OPS       = 400;               // length of one random phase
    // two full sweeps, two random phases, config accesses and drains
    localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * GLB_WORDS + 2 * RAND_OPS + 64;
    localparam int WATCHDOG_NS    = PLANNED_CYCLES * CLK_PERIOD * 3 / 2;

    logic                      clk;
    logic                      reset;
    logic                      host_wr_en;
    logic [GLB_ADDR_WIDTH-1:0] host_wr_addr;
    bank_data_t                host_wr_data;
    logic                      host_rd_en;
    logic [GLB_ADDR_WIDTH-1:0] host_rd_addr;
    bank_data_t                host_rd_data;
    cfg_req_t                  cfg;
    logic [CFG_DATA_WIDTH-1:0] cfg_rd_data;

    logic [31:0] rng_state;                            // xorshift state
    int          cyc;                                  // cycle index since reset
    bank_data_t  last_rd;                              // last read result on the output

    `include "glb_model.svh"

    global_buffer #(.NUM_BANKS(NUM_BANKS)) i_global_buffer (
        .clk          (clk),
        .reset        (reset),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (host_rd_data),
        .cfg          (cfg),
        .cfg_rd_data  (cfg_rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bank_data_t random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = xorshift32();
        lo = xorshift32();
        return {hi, lo};
    endfunction

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // move to the next cycle, check the read output, release the strobes
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        cyc++;
        if (exp_cycle.size() != 0 && exp_cycle[0] + 2 == cyc) begin
            last_rd = exp_data.pop_front();            // result due in n+2
            void'(exp_cycle.pop_front());
        end
        check_equal("host_rd_data", last_rd, host_rd_data);  // new result or held one
        host_wr_en = 1'b0;
        host_rd_en = 1'b0;
        cfg        = '0;
    endtask

    task automatic host_write(input logic [GLB_ADDR_WIDTH-1:0] addr, input bank_data_t data);
        host_wr_en   = 1'b1;
        host_wr_addr = addr;
        host_wr_data = data;
        store_expected(addr, data);
        next_cycle();
    endtask

    task automatic host_read(input logic [GLB_ADDR_WIDTH-1:0] addr);
        host_rd_en   = 1'b1;
        host_rd_addr = addr;
        exp_data.push_back(expected_read(addr));
        exp_cycle.push_back(cyc);
        next_cycle();
    endtask

    task automatic cfg_write(input logic [CFG_ADDR_WIDTH-1:0] addr,
                             input logic [CFG_DATA_WIDTH-1:0] data);
        cfg.wr_en = 1'b1;
        cfg.addr  = addr;
        cfg.data  = data;
        if (addr == CFG_BANK_ENABLE) begin
            model_mask = data[NUM_BANKS-1:0];          // upper bits have no effect
        end else if (addr == CFG_DROP_COUNT) begin
            model_drops = 0;
        end
        next_cycle();                                  // in effect from here on
    endtask

    task automatic cfg_read_check(input logic [CFG_ADDR_WIDTH-1:0] addr,
                                  input logic [63:0] expected, input string name);
        cfg.rd_en = 1'b1;
        cfg.addr  = addr;
        next_cycle();
        check_equal(name, expected, 64'(cfg_rd_data)); // valid one cycle after the strobe
    endtask

    // mix of writes, reads and idle cycles, reads often back to back
    task automatic random_traffic(input int ops);
        logic [31:0] op;
        for (int i = 0; i < ops; i++) begin
            op = xorshift32() % 4;
            case (op)
                0:       host_write(GLB_ADDR_WIDTH'(xorshift32()), random_word());
                1, 2:    host_read(GLB_ADDR_WIDTH'(xorshift32()));
                default: next_cycle();
            endcase
        end
        next_cycle();                                  // let the last reads complete
        next_cycle();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] mask_word;
        clk          = 1'b0;
        reset        = 1'b1;
        host_wr_en   = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd_en   = 1'b0;
        host_rd_addr = '0;
        cfg          = '0;
        rng_state    = 32'd35171;
        cyc          = 0;
        last_rd      = '0;
        model_mask   = '1;
        model_drops  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        // reset values
        check_equal("host_rd_data", 64'd0, host_rd_data);
        cfg_read_check(CFG_BANK_ENABLE, (64'd1 << NUM_BANKS) - 64'd1, "cfg_rd_data mask");
        cfg_read_check(CFG_DROP_COUNT, 64'd0, "cfg_rd_data drop count");
        cfg_read_check(2'd2, 64'd0, "cfg_rd_data unmapped");

        // fill every word so the model is fully known
        for (int a = 0; a < GLB_WORDS; a++) begin
            host_write(GLB_ADDR_WIDTH'(a), random_word());
        end
        random_traffic(RAND_OPS);

        // disable a random set of banks, never all of them on
        mask_word = xorshift32();
        if (mask_word[NUM_BANKS-1:0] == '1) begin
            mask_word[0] = 1'b0;
        end
        cfg_write(CFG_BANK_ENABLE, mask_word);
        cfg_read_check(CFG_BANK_ENABLE, 64'(model_mask), "cfg_rd_data mask");
        random_traffic(RAND_OPS);

        // drop counter matches, then clears on write
        cfg_read_check(CFG_DROP_COUNT, 64'(model_drops), "cfg_rd_data drop count");
        cfg_write(CFG_DROP_COUNT, xorshift32());
        cfg_read_check(CFG_DROP_COUNT, 64'd0, "cfg_rd_data drop count");

        // all banks back on, dropped writes must not have touched memory
        cfg_write(CFG_BANK_ENABLE, 32'hffff_ffff);
        for (int a = 0; a < GLB_WORDS; a++) begin
            host_read(GLB_ADDR_WIDTH'(a));
        end
        next_cycle();
        next_cycle();

        $display("Simulation passed");
        $finish;
    end

    // ends a run that takes far longer than expected
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the test did not finish in the expected time");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule
